//--- rtl/pipe_defs.svh
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

// datapath and register width
`define XLEN 32

// architectural integer registers
`define NUM_REGS 32

// stage slots between issue and writeback, 2 or more
`define PIPE_DEPTH 3

`endif

//--- rtl/rv32i_pipe_pkg.sv
`include "pipe_defs.svh"

package rv32i_pipe_pkg;

    typedef logic [`XLEN-1:0] rv32i_word;

    // major opcodes handled by issue, anything else is illegal
    typedef enum logic [6:0] {
        op_reg = 7'b0110011,
        op_imm = 7'b0010011,
        op_lui = 7'b0110111
    } rv32i_opcode;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl
    } alu_ops;

    // one in-flight instruction, also the retire report
    typedef struct packed {
        logic       valid;
        logic       illegal;
        logic [4:0] rd;
        rv32i_word  result;
    } slot_t;

    // sources of the instruction waiting at issue
    typedef struct packed {
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic       rs1_used;
        logic       rs2_used;
    } src_t;

endpackage : rv32i_pipe_pkg

//--- rtl/issue_unit.sv
`timescale 1ns/1ps
`include "pipe_defs.svh"

module issue_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_valid,
    input  rv32i_pipe_pkg::rv32i_word instr,
    input  logic [`PIPE_DEPTH-1:0]    hazard,
    input  rv32i_pipe_pkg::rv32i_word rs1_data,
    input  rv32i_pipe_pkg::rv32i_word rs2_data,
    output logic [4:0]                rs1_addr,
    output logic [4:0]                rs2_addr,
    output rv32i_pipe_pkg::src_t      issue_src,
    output logic                      stall,
    output rv32i_pipe_pkg::slot_t     launch
);

    import rv32i_pipe_pkg::*;

    rv32i_opcode opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    rv32i_word   imm_i;
    rv32i_word   imm_u;
    alu_ops      alu_op;
    logic        use_imm;
    logic        illegal;
    logic        rs1_used;
    logic        rs2_used;
    rv32i_word   operand_b;
    rv32i_word   alu_out;
    slot_t       launch_d;

    // instruction fields
    assign opcode   = rv32i_opcode'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign imm_i    = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_u    = {instr[31:12], 12'b0};

    always_comb begin
        alu_op   = alu_add;
        use_imm  = 1'b0;
        illegal  = 1'b0;
        rs1_used = 1'b0;
        rs2_used = 1'b0;
        case (opcode)
            op_reg: begin
                rs1_used = 1'b1;
                rs2_used = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: alu_op = alu_add;
                    10'b0100000_000: alu_op = alu_sub;
                    10'b0000000_111: alu_op = alu_and;
                    10'b0000000_110: alu_op = alu_or;
                    10'b0000000_100: alu_op = alu_xor;
                    10'b0000000_010: alu_op = alu_slt;
                    10'b0000000_001: alu_op = alu_sll;
                    10'b0000000_101: alu_op = alu_srl;
                    default:         illegal = 1'b1;
                endcase
            end
            op_imm: begin
                use_imm  = 1'b1;
                rs1_used = 1'b1;
                case (funct3)
                    3'b000:  alu_op = alu_add;
                    3'b111:  alu_op = alu_and;
                    3'b110:  alu_op = alu_or;
                    3'b100:  alu_op = alu_xor;
                    3'b010:  alu_op = alu_slt;
                    // shifts and sltiu are not supported
                    default: illegal = 1'b1;
                endcase
            end
            op_lui: begin
                use_imm = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
        // illegal words read nothing, so they never stall
        if (illegal) begin
            rs1_used = 1'b0;
            rs2_used = 1'b0;
        end
    end

    assign operand_b = use_imm ? imm_i : rs2_data;

    always_comb begin
        case (alu_op)
            alu_add: alu_out = rs1_data + operand_b;
            alu_sub: alu_out = rs1_data - operand_b;
            alu_and: alu_out = rs1_data & operand_b;
            alu_or:  alu_out = rs1_data | operand_b;
            alu_xor: alu_out = rs1_data ^ operand_b;
            alu_slt: alu_out = {{(`XLEN-1){1'b0}}, $signed(rs1_data) < $signed(operand_b)};
            alu_sll: alu_out = rs1_data << operand_b[4:0];
            alu_srl: alu_out = rs1_data >> operand_b[4:0];
            default: alu_out = rs1_data + operand_b;
        endcase
    end

    assign issue_src = '{rs1: rs1_addr, rs2: rs2_addr, rs1_used: rs1_used, rs2_used: rs2_used};

    // hold the word while any slot still owes one of its sources
    assign stall = instr_valid && (|hazard);

    always_comb begin
        launch_d.valid   = instr_valid && !stall;
        launch_d.illegal = illegal;
        launch_d.rd      = instr[11:7];
        launch_d.result  = (opcode == op_lui) ? imm_u : alu_out;
    end

    // a bubble goes out while stalled or idle, slot 0 loads it at the accept edge
    assign launch = launch_d;

endmodule : issue_unit

//--- rtl/stage_slot.sv
`timescale 1ns/1ps

module stage_slot (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv32i_pipe_pkg::slot_t in,
    input  rv32i_pipe_pkg::src_t  issue_src,
    output rv32i_pipe_pkg::slot_t out,
    output logic                  hazard
);

    logic writes_reg;
    logic rs1_hit;
    logic rs2_hit;

    // slots advance every cycle, no hold
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out <= '0;
        end else begin
            out <= in;
        end
    end

    // x0 and illegal words never produce a value to wait for
    assign writes_reg = out.valid && !out.illegal && (out.rd != 5'd0);

    assign rs1_hit = issue_src.rs1_used && (issue_src.rs1 == out.rd);
    assign rs2_hit = issue_src.rs2_used && (issue_src.rs2 == out.rd);

    assign hazard = writes_reg && (rs1_hit || rs2_hit);

endmodule : stage_slot

//--- rtl/writeback_unit.sv
`timescale 1ns/1ps
`include "pipe_defs.svh"

module writeback_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  rv32i_pipe_pkg::slot_t     retire,
    input  logic [4:0]                rs1_addr,
    input  logic [4:0]                rs2_addr,
    output rv32i_pipe_pkg::rv32i_word rs1_data,
    output rv32i_pipe_pkg::rv32i_word rs2_data,
    output rv32i_pipe_pkg::slot_t     wb
);

    import rv32i_pipe_pkg::*;

    rv32i_word regs [`NUM_REGS];
    logic      wr_en;
    slot_t     wb_d;

    assign wr_en = retire.valid && !retire.illegal && (retire.rd != 5'd0);

    // x0 is never written, so it stays at its reset value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[retire.rd] <= retire.result;
        end
    end

    // read after the write edge sees the new value
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    // report carries what actually landed in the register file
    always_comb begin
        wb_d = retire;
        if (retire.illegal || (retire.rd == 5'd0)) begin
            wb_d.result = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            wb <= wb_d;
        end
    end

endmodule : writeback_unit

//--- rtl/pipe_core.sv
`timescale 1ns/1ps
`include "pipe_defs.svh"

module pipe_core (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_valid,
    input  rv32i_pipe_pkg::rv32i_word instr,
    output logic                      stall,
    output rv32i_pipe_pkg::slot_t     wb
);

    import rv32i_pipe_pkg::*;

    // chain[0] is the launch, chain[PIPE_DEPTH] goes to retire
    slot_t                 chain [`PIPE_DEPTH+1];
    src_t                  issue_src;
    logic [`PIPE_DEPTH-1:0] hazard;
    logic [4:0]            rs1_addr;
    logic [4:0]            rs2_addr;
    rv32i_word             rs1_data;
    rv32i_word             rs2_data;

    issue_unit u_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .hazard      (hazard),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .issue_src   (issue_src),
        .stall       (stall),
        .launch      (chain[0])
    );

    genvar k;
    generate
        for (k = 0; k < `PIPE_DEPTH; k++) begin : g_slot
            stage_slot u_slot (
                .clk       (clk),
                .rst_n     (rst_n),
                .in        (chain[k]),
                .issue_src (issue_src),
                .out       (chain[k+1]),
                .hazard    (hazard[k])
            );
        end
    endgenerate

    writeback_unit u_wb (
        .clk      (clk),
        .rst_n    (rst_n),
        .retire   (chain[`PIPE_DEPTH]),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

endmodule : pipe_core

//--- verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
    end

    always begin
        #2 clk = ~clk;
    end

endmodule : tb_clock

//--- verification/pipe_asserts.sv
`timescale 1ns/1ps
`include "pipe_defs.svh"

module pipe_asserts (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  instr_valid,
    input logic                  stall,
    input rv32i_pipe_pkg::slot_t wb
);

    int fail_count = 0;

    a_stall_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> instr_valid)
        else begin
            $error("stall raised without a valid instruction");
            fail_count++;
        end

    // covers the reset cycles and the first cycle out of reset
    a_no_wb_in_reset: assert property (@(posedge clk) !rst_n |=> !wb.valid)
        else begin
            $error("wb valid during or right after reset");
            fail_count++;
        end

    a_x0_result_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (wb.valid && wb.rd == 5'd0) |-> (wb.result == '0))
        else begin
            $error("wb to x0 with nonzero result");
            fail_count++;
        end

    // a producer leaves the last slot after at most PIPE_DEPTH cycles
    a_stall_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(stall) |-> ##[1:`PIPE_DEPTH] !stall)
        else begin
            $error("stall held longer than the slot chain");
            fail_count++;
        end

endmodule : pipe_asserts

bind pipe_core pipe_asserts u_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .stall       (stall),
    .wb          (wb)
);

//--- verification/tb_top.sv
`timescale 1ns/1ps
`include "pipe_defs.svh"

module tb_top;

    import rv32i_pipe_pkg::*;

    // accept edge to the first cycle of wb valid
    localparam int unsigned retire_latency = `PIPE_DEPTH;
    localparam logic [9:0] r_codes [8] = '{10'b0000000_000, 10'b0100000_000, 10'b0000000_111,
        10'b0000000_110, 10'b0000000_100, 10'b0000000_010, 10'b0000000_001, 10'b0000000_101};
    localparam logic [2:0] i_codes [5] = '{3'b000, 3'b111, 3'b110, 3'b100, 3'b010};

    typedef struct packed {
        slot_t       slot;
        int unsigned accepted;
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    rv32i_word   instr;
    logic        stall;
    slot_t       wb;
    rv32i_word   shadow [`NUM_REGS];
    expect_t     exp_q [$];
    int unsigned cycle_count = 0;
    int          pass_count = 0;
    int          error_count = 0;
    int          errors_at_start;
    int          stall_seen;
    string       test_name;

    tb_clock u_clock (.clk(clk));

    pipe_core UUT (.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
        .stall(stall), .wb(wb));

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // expected retire report, operands from the registers in program order
    function automatic slot_t predict(input rv32i_word regs [`NUM_REGS], input rv32i_word w);
        slot_t     s;
        rv32i_word a;
        rv32i_word b;
        logic      is_op;
        logic      legal;
        s = '0;
        s.valid = 1'b1;
        s.rd = w[11:7];
        is_op = (w[6:0] == 7'b0110011);
        a = regs[w[19:15]];
        b = is_op ? regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        case (w[6:0])
            7'b0110111: legal = 1'b1;
            7'b0110011: legal = (w[31:25] == 7'h00 && w[14:12] != 3'b011)
                                || (w[31:25] == 7'h20 && w[14:12] == 3'b000);
            7'b0010011: legal = !(w[14:12] inside {3'b001, 3'b011, 3'b101});
            default:    legal = 1'b0;
        endcase
        case (w[14:12])
            3'b000:  s.result = (is_op && w[30]) ? a - b : a + b;
            3'b001:  s.result = a << b[4:0];
            3'b010:  s.result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            3'b100:  s.result = a ^ b;
            3'b101:  s.result = a >> b[4:0];
            3'b110:  s.result = a | b;
            default: s.result = a & b;
        endcase
        if (w[6:0] == 7'b0110111) s.result = {w[31:12], 12'h000};
        s.illegal = !legal;
        if (!legal || s.rd == 5'd0) s.result = '0;
        return s;
    endfunction

    function automatic rv32i_word r_op(input logic [9:0] code, input int rd, input int rs1,
                                       input int rs2);
        return {code[9:3], 5'(rs2), 5'(rs1), code[2:0], 5'(rd), 7'b0110011};
    endfunction

    function automatic rv32i_word i_op(input logic [2:0] f3, input int rd, input int rs1,
                                       input logic [11:0] imm);
        return {imm, 5'(rs1), f3, 5'(rd), 7'b0010011};
    endfunction

    function automatic rv32i_word lui_op(input int rd, input logic [19:0] imm);
        return {imm, 5'(rd), 7'b0110111};
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s %s expected %h actual %h", test_name, what, expected, actual);
            error_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic abort_on_timeout(input string why);
        $display("%s for 50 cycles in test %s", why, test_name);
        $display("Regression failed");
        $finish;
    endtask

    // entered and left 1 ns after a rising edge
    task automatic issue(input rv32i_word w);
        int      waited;
        expect_t e;
        waited = 0;
        instr_valid = 1'b1;
        instr = w;
        @(negedge clk);
        while (stall) begin
            if (waited == 50) abort_on_timeout("stall stayed high");
            waited++;
            stall_seen++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        e.slot = predict(shadow, w);
        e.accepted = cycle_count;
        exp_q.push_back(e);
        if (!e.slot.illegal && e.slot.rd != 5'd0) begin
            shadow[e.slot.rd] = e.slot.result;
        end
        instr_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        instr_valid = 1'b0;
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited == 50) abort_on_timeout("instructions did not retire");
            waited++;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errors_at_start = error_count;
        stall_seen = 0;
    endtask

    task automatic end_test();
        $display("test %s done, %0d errors", test_name, error_count - errors_at_start);
    endtask

    // wb is stable at the falling edge
    initial begin : compare
        expect_t e;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && wb.valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("retirement in test %s with nothing outstanding", test_name);
                    error_count++;
                end else begin
                    e = exp_q.pop_front();
                    check_value("rd", e.slot.rd, wb.rd);
                    check_value("illegal", e.slot.illegal, wb.illegal);
                    check_value("result", e.slot.result, wb.result);
                    check_value("latency", retire_latency, cycle_count - e.accepted);
                end
            end
        end
    end

    initial begin : stimulus
        rv32i_word w;
        int        rd;
        int        rs1;
        int        rs2;
        void'($urandom(10679));
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        foreach (shadow[i]) shadow[i] = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        begin_test("reset");
        @(negedge clk);
        check_value("wb valid", 0, wb.valid);
        @(posedge clk);
        #1;
        for (int r = 1; r < `NUM_REGS; r++) begin
            issue(i_op(3'b000, r, r, 12'h000));
        end
        drain();
        check_value("stall cycles", 0, stall_seen);
        end_test();

        begin_test("independent");
        issue(lui_op(1, 20'h12345));
        issue(i_op(3'b000, 2, 0, 12'h7f3));
        issue(i_op(3'b000, 3, 0, 12'h805));
        issue(lui_op(4, 20'hfedcb));
        issue(i_op(3'b000, 5, 0, 12'h013));
        drain();
        for (int k = 0; k < 8; k++) begin
            issue(r_op(r_codes[k], 10 + k, 1 + k % 4, 2 + k % 4));
        end
        issue(r_op(10'b0000000_001, 18, 1, 5));
        for (int k = 0; k < 5; k++) begin
            issue(i_op(i_codes[k], 20 + k, 1 + k, 12'hf0f - 12'(k * 7)));
        end
        drain();
        check_value("stall cycles", 0, stall_seen);
        end_test();

        begin_test("raw hazard");
        issue(i_op(3'b000, 6, 1, 12'h011));
        issue(r_op(10'b0000000_000, 7, 6, 3));
        check_value("stall on rs1", 1, stall_seen > 0);
        stall_seen = 0;
        issue(r_op(10'b0100000_000, 8, 4, 7));
        check_value("stall on rs2", 1, stall_seen > 0);
        stall_seen = 0;
        // rs2 field matches x9 but is unused
        issue(i_op(3'b000, 9, 1, 12'h003));
        issue(i_op(3'b110, 26, 2, 12'h009));
        issue(lui_op(27, 20'h00900));
        check_value("no stall on unused rs2", 0, stall_seen);
        drain();
        end_test();

        begin_test("x0 writes");
        issue(i_op(3'b000, 0, 1, 12'h055));
        issue(r_op(10'b0000000_110, 0, 1, 2));
        issue(lui_op(0, 20'habcde));
        drain();
        issue(r_op(10'b0000000_000, 12, 0, 0));
        issue(i_op(3'b110, 13, 0, 12'h000));
        drain();
        end_test();

        begin_test("illegal");
        issue(i_op(3'b000, 14, 1, 12'h001));
        issue({12'h004, 5'd14, 3'b010, 5'd2, 7'b0000011});
        issue({7'h00, 5'd14, 5'd1, 3'b010, 5'd0, 7'b0100011});
        issue(r_op(10'b0000001_000, 3, 14, 14));
        issue(i_op(3'b001, 4, 14, 12'h003));
        check_value("illegal stall", 0, stall_seen);
        drain();
        issue(i_op(3'b000, 22, 2, 12'h000));
        issue(i_op(3'b000, 23, 3, 12'h000));
        issue(i_op(3'b000, 24, 4, 12'h000));
        drain();
        end_test();

        begin_test("random");
        for (int n = 0; n < 300; n++) begin
            if ($urandom_range(0, 5) == 0) begin
                idle($urandom_range(1, 3));
            end
            rd = $urandom_range(0, 11);
            rs1 = $urandom_range(0, 11);
            rs2 = $urandom_range(0, 11);
            case ($urandom_range(0, 9))
                0, 1, 2, 3: w = r_op(r_codes[$urandom_range(0, 7)], rd, rs1, rs2);
                4, 5, 6:    w = i_op(i_codes[$urandom_range(0, 4)], rd, rs1, 12'($urandom));
                7, 8:       w = lui_op(rd, 20'($urandom));
                default:    w = $urandom;
            endcase
            issue(w);
        end
        drain();
        end_test();

        if (UUT.u_asserts.fail_count != 0) begin
            $display("%0d assertion failures in the pipeline", UUT.u_asserts.fail_count);
            error_count += UUT.u_asserts.fail_count;
        end
        $display("%0d checks passed, %0d errors", pass_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : tb_top

//--- project.f
+incdir+rtl
rtl/rv32i_pipe_pkg.sv
rtl/issue_unit.sv
rtl/stage_slot.sv
rtl/writeback_unit.sv
rtl/pipe_core.sv
verification/tb_clock.sv
verification/pipe_asserts.sv
verification/tb_top.sv
